//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  exe_pkg::exe_op_e      op,
    input  logic [exe_pkg::xlen-1:0] a,
    input  logic [exe_pkg::xlen-1:0] b,
    output logic [exe_pkg::xlen-1:0] result
);
    import exe_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_slt:  result = {{(xlen-1){1'b0}}, lt_s};
            op_sltu: result = {{(xlen-1){1'b0}}, lt_u};
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_nor:  result = ~(a | b);
            op_sll:  result = a << shamt;
            op_srl:  result = a >> shamt;
            op_sra:  result = $unsigned($signed(a) >>> shamt);
            // divide opcodes come from the divider
            default: result = '0;
        endcase
    end

endmodule

//--- div_counter.sv
`timescale 1ns/1ps

module div_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic step_en,
    input  logic busy,
    output logic last
);
    import exe_pkg::*;

    logic [div_cnt_w-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (!busy) begin
            count <= '0;
        end else if (step_en) begin
            count <= count + 1'b1;
        end
    end

    assign last = step_en && (count == div_cnt_w'(div_steps - 1));

endmodule

//--- div_datapath.sv
`timescale 1ns/1ps

module div_datapath (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     step_en,
    input  exe_pkg::exe_op_e         op,
    input  logic [exe_pkg::xlen-1:0] a,
    input  logic [exe_pkg::xlen-1:0] b,
    output logic [exe_pkg::xlen-1:0] result
);
    import exe_pkg::*;

    logic            is_signed;
    logic            a_neg;
    logic            b_neg;
    logic            q_neg;
    logic            r_neg;
    logic            rem_sel;
    logic [xlen-1:0] rem_q;
    logic [xlen-1:0] quo_q;
    logic [xlen-1:0] dvs_q;
    logic [xlen:0]   rem_shift;
    logic [xlen:0]   diff;

    assign is_signed = (op == op_div_w) || (op == op_mod_w);
    assign a_neg     = is_signed && a[xlen-1];
    assign b_neg     = is_signed && b[xlen-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_neg   <= 1'b0;
            r_neg   <= 1'b0;
            rem_sel <= 1'b0;
        end else if (start) begin
            q_neg   <= a_neg ^ b_neg;
            r_neg   <= a_neg;
            rem_sel <= (op == op_mod_w) || (op == op_mod_wu);
        end
    end

    // restoring step, next dividend bit shifts into the partial remainder
    assign rem_shift = {rem_q, quo_q[xlen-1]};
    assign diff      = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= a_neg ? -a : a;
            dvs_q <= b_neg ? -b : b;
        end else if (step_en) begin
            rem_q <= diff[xlen] ? rem_shift[xlen-1:0] : diff[xlen-1:0];
            quo_q <= {quo_q[xlen-2:0], ~diff[xlen]};
        end
    end

    assign result = rem_sel ? (r_neg ? -rem_q : rem_q)
                            : (q_neg ? -quo_q : quo_q);

endmodule

//--- div_fsm.sv
`timescale 1ns/1ps

module div_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic flush,
    input  logic div_req,
    input  logic last,
    output logic start,
    output logic step_en,
    output logic busy,
    output logic done
);
    import exe_pkg::*;

    div_state_e state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else if (flush) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (div_req) state <= st_busy;
                st_busy: if (last) state <= st_done;
                default: state <= st_idle;
            endcase
        end
    end

    assign start   = (state == st_idle) && div_req;
    assign busy    = (state == st_busy);
    assign step_en = busy;
    assign done    = (state == st_done);

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done);

    // start is taken from idle and always lands in busy
    a_start_from_idle: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> (state == st_idle) ##1 busy);

endmodule

//--- exe.sv
`timescale 1ns/1ps

module exe (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  exe_pkg::issue_t          issue0,
    input  exe_pkg::issue_t          issue1,
    input  logic [exe_pkg::xlen-1:0] rf_data00,
    input  logic [exe_pkg::xlen-1:0] rf_data01,
    input  logic [exe_pkg::xlen-1:0] rf_data10,
    input  logic [exe_pkg::xlen-1:0] rf_data11,
    output exe_pkg::wb_t             wb0,
    output exe_pkg::wb_t             wb1,
    output logic                     stall
);
    import exe_pkg::*;

    logic [xlen-1:0] src00, src01, src10, src11;
    logic [xlen-1:0] b0, b1;
    logic [xlen-1:0] alu0_res, alu1_res, div_res;
    logic            is_div0, div_req;
    logic            div_start, div_step, div_busy, div_done, div_last;
    wb_t             ex1_0, ex1_1, ex1_0_d, ex1_1_d;

    forward u_forward (
        .rj0(issue0.rj), .rk0(issue0.rk), .rj1(issue1.rj), .rk1(issue1.rk),
        .rf_data00(rf_data00), .rf_data01(rf_data01),
        .rf_data10(rf_data10), .rf_data11(rf_data11),
        .ex1_0(ex1_0), .ex1_1(ex1_1), .wb0(wb0), .wb1(wb1),
        .src00(src00), .src01(src01), .src10(src10), .src11(src11)
    );

    assign b0 = issue0.use_imm ? issue0.imm : src01;
    assign b1 = issue1.use_imm ? issue1.imm : src11;

    alu alu0 (.op(issue0.op), .a(src00), .b(b0), .result(alu0_res));
    alu alu1 (.op(issue1.op), .a(src10), .b(b1), .result(alu1_res));

    assign is_div0 = issue0.op inside {op_div_w, op_div_wu, op_mod_w, op_mod_wu};
    assign div_req = issue0.en && is_div0 && !flush;
    // held until the done cycle lets the bundle through
    assign stall   = div_req && !div_done;

    div_fsm u_div_fsm (
        .clk(clk), .arst_n(arst_n), .flush(flush), .div_req(div_req), .last(div_last),
        .start(div_start), .step_en(div_step), .busy(div_busy), .done(div_done)
    );

    div_counter u_div_counter (
        .clk(clk), .arst_n(arst_n), .step_en(div_step), .busy(div_busy), .last(div_last)
    );

    div_datapath u_div_datapath (
        .clk(clk), .arst_n(arst_n), .start(div_start), .step_en(div_step),
        .op(issue0.op), .a(src00), .b(b0), .result(div_res)
    );

    // r0 writes never enter the pipe
    assign ex1_0_d = '{en: issue0.en && (issue0.rd != '0), rd: issue0.rd,
                       data: is_div0 ? div_res : alu0_res};
    assign ex1_1_d = '{en: issue1.en && (issue1.rd != '0), rd: issue1.rd, data: alu1_res};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex1_0 <= '0;
            ex1_1 <= '0;
            wb0   <= '0;
            wb1   <= '0;
        end else if (flush) begin
            ex1_0 <= '0;
            ex1_1 <= '0;
            wb0   <= '0;
            wb1   <= '0;
        end else if (!stall) begin
            ex1_0 <= ex1_0_d;
            ex1_1 <= ex1_1_d;
            wb0   <= ex1_0;
            wb1   <= ex1_1;
        end
    end

    a_no_wb_r0: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb0.en && wb0.rd == '0) && !(wb1.en && wb1.rd == '0));

endmodule

//--- exe_pkg.sv
package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_aw     = 5;
    localparam int div_steps  = 32;
    localparam int div_cnt_w  = $clog2(div_steps);

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_sll,
        op_srl,
        op_sra,
        op_div_w,
        op_div_wu,
        op_mod_w,
        op_mod_wu
    } exe_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } div_state_e;

    // one instruction as presented by issue
    typedef struct packed {
        logic              en;
        exe_op_e           op;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rj;
        logic [reg_aw-1:0] rk;
        logic [xlen-1:0]   imm;
        logic              use_imm;
    } issue_t;

    typedef struct packed {
        logic              en;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   data;
    } wb_t;

endpackage

//--- forward.sv
`timescale 1ns/1ps

module forward (
    input  logic [exe_pkg::reg_aw-1:0] rj0,
    input  logic [exe_pkg::reg_aw-1:0] rk0,
    input  logic [exe_pkg::reg_aw-1:0] rj1,
    input  logic [exe_pkg::reg_aw-1:0] rk1,
    input  logic [exe_pkg::xlen-1:0]   rf_data00,
    input  logic [exe_pkg::xlen-1:0]   rf_data01,
    input  logic [exe_pkg::xlen-1:0]   rf_data10,
    input  logic [exe_pkg::xlen-1:0]   rf_data11,
    input  exe_pkg::wb_t               ex1_0,
    input  exe_pkg::wb_t               ex1_1,
    input  exe_pkg::wb_t               wb0,
    input  exe_pkg::wb_t               wb1,
    output logic [exe_pkg::xlen-1:0]   src00,
    output logic [exe_pkg::xlen-1:0]   src01,
    output logic [exe_pkg::xlen-1:0]   src10,
    output logic [exe_pkg::xlen-1:0]   src11
);
    import exe_pkg::*;

    // later checks override earlier ones, youngest last
    function automatic logic [xlen-1:0] pick(input logic [reg_aw-1:0] addr,
                                             input logic [xlen-1:0]   rf);
        logic [xlen-1:0] val;
        val = rf;
        if (wb0.en && wb0.rd == addr) val = wb0.data;
        if (wb1.en && wb1.rd == addr) val = wb1.data;
        if (ex1_0.en && ex1_0.rd == addr) val = ex1_0.data;
        if (ex1_1.en && ex1_1.rd == addr) val = ex1_1.data;
        return val;
    endfunction

    always_comb begin
        src00 = pick(rj0, rf_data00);
        src01 = pick(rk0, rf_data01);
        src10 = pick(rj1, rf_data10);
        src11 = pick(rk1, rf_data11);
    end

endmodule

//--- list.f
exe_pkg.sv
alu.sv
forward.sv
div_fsm.sv
div_counter.sv
div_datapath.sv
exe.sv
tb_clk.sv
tb_checker.sv
tb_exe.sv

//--- run.sh
#!/bin/sh
# build and run the exe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_exe -o tb_exe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" sim.log; then
    exit 0
fi
exit 1

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            stall,
    input  exe_pkg::issue_t issue0,
    input  exe_pkg::wb_t    wb0,
    input  exe_pkg::wb_t    wb1,
    output int              mismatches,
    output int              other_errs,
    output int              checked
);
    import exe_pkg::*;

    wb_t  expq[$];
    logic fresh;
    logic held;
    wb_t  wb0_q;
    wb_t  wb1_q;
    int   div_wait;
    logic div_issued;
    logic stall_exp;

    // a divide holds issue for the idle cycle and div_steps busy cycles
    assign div_issued = issue0.en && !flush
                        && (issue0.op inside {op_div_w, op_div_wu, op_mod_w, op_mod_wu});
    assign stall_exp  = div_issued && (div_wait < div_steps + 1);

    task automatic expect_wb(input logic [reg_aw-1:0] rd, input logic [xlen-1:0] data);
        wb_t e;
        e.en = 1'b1;
        e.rd = rd;
        e.data = data;
        expq.push_back(e);
    endtask

    task automatic discard_all();
        expq.delete();
    endtask

    function automatic int pending_count();
        return expq.size();
    endfunction

    task automatic compare_wb(input string name, input wb_t got);
        wb_t e;
        if (got.en && got.rd == '0) begin
            $display("%0t %s: enabled writeback to register 0", $time, name);
            other_errs++;
        end else if (got.en && expq.size() == 0) begin
            $display("%0t %s: writeback to r%0d with nothing expected", $time, name, got.rd);
            other_errs++;
        end else if (got.en) begin
            e = expq.pop_front();
            checked++;
            if (got.rd !== e.rd) begin
                $display("[FAIL] %0t %s.rd expected %0d got %0d", $time, name, e.rd, got.rd);
                mismatches++;
            end
            if (got.data !== e.data) begin
                $display("[FAIL] %0t %s.data expected %h got %h", $time, name, e.data, got.data);
                mismatches++;
            end
        end
    endtask

    // wb only carries a new entry after an edge with no stall and no flush
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mismatches = 0;
            other_errs = 0;
            checked = 0;
            fresh <= 1'b0;
            held <= 1'b0;
            div_wait <= 0;
        end else begin
            if (fresh) begin
                compare_wb("wb0", wb0);
                compare_wb("wb1", wb1);
            end
            if (held && (wb0 !== wb0_q || wb1 !== wb1_q)) begin
                $display("%0t writeback changed while the pipe was stalled", $time);
                other_errs++;
            end
            if (stall !== stall_exp) begin
                $display("[FAIL] %0t stall expected %b got %b", $time, stall_exp, stall);
                mismatches++;
            end
            div_wait <= stall_exp ? div_wait + 1 : 0;
            fresh <= !stall && !flush;
            held <= stall && !flush;
            wb0_q <= wb0;
            wb1_q <= wb1;
        end
    end

endmodule

//--- tb_clk.sv
`timescale 1ns/1ps

module tb_clk (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 8 rising edges in reset, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- tb_exe.sv
`timescale 1ns/1ps

module tb_exe;
    import exe_pkg::*;

    localparam int n_random   = 400;
    localparam int n_directed = 4;
    localparam int max_cycles = (n_random + n_directed) * 40 + 100;

    logic            clk, arst_n, flush, stall;
    issue_t          issue0, issue1;
    logic [xlen-1:0] rf_data00, rf_data01, rf_data10, rf_data11;
    wb_t             wb0, wb1;
    int              mismatches, other_errs, checked;
    logic [xlen-1:0] shadow_rf [32];
    logic [xlen-1:0] model_rf [32];
    int              seed;
    int              cycles;

    tb_clk u_clk (.clk(clk), .arst_n(arst_n));

    exe dut0 (
        .clk(clk), .arst_n(arst_n), .flush(flush), .issue0(issue0), .issue1(issue1),
        .rf_data00(rf_data00), .rf_data01(rf_data01),
        .rf_data10(rf_data10), .rf_data11(rf_data11),
        .wb0(wb0), .wb1(wb1), .stall(stall)
    );

    tb_checker chk0 (
        .clk(clk), .arst_n(arst_n), .flush(flush), .stall(stall), .issue0(issue0),
        .wb0(wb0), .wb1(wb1),
        .mismatches(mismatches), .other_errs(other_errs), .checked(checked)
    );

    // lane 1 written last so it wins on the same rd
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int k = 0; k < 32; k++) shadow_rf[k] <= '0;
        end else begin
            if (wb0.en) shadow_rf[wb0.rd] <= wb0.data;
            if (wb1.en) shadow_rf[wb1.rd] <= wb1.data;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles > max_cycles) begin
                $display("timeout: run stopped after %0d cycles", cycles);
                $display("tests failed");
                $finish;
            end
        end
    end

    function automatic logic [xlen-1:0] model_result(input exe_op_e op,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        logic [xlen-1:0] am, bm, qm, rm;
        logic            sgn, an, bn;
        sgn = (op == op_div_w) || (op == op_mod_w);
        an = sgn && a[xlen-1];
        bn = sgn && b[xlen-1];
        am = an ? -a : a;
        bm = bn ? -b : b;
        qm = (bm == '0) ? '1 : am / bm;
        rm = (bm == '0) ? am : am % bm;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_slt:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: return {{(xlen-1){1'b0}}, a < b};
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return $signed(a) >>> b[4:0];
            op_div_w, op_div_wu: return (an != bn) ? -qm : qm;
            default: return an ? -rm : rm;
        endcase
    endfunction

    function automatic issue_t insn(input exe_op_e op, input logic [reg_aw-1:0] rd,
                                    input logic [reg_aw-1:0] rj, input logic [reg_aw-1:0] rk,
                                    input logic [xlen-1:0] imm, input logic use_imm);
        issue_t i;
        i.en = 1'b1;
        i.op = op;
        i.rd = rd;
        i.rj = rj;
        i.rk = rk;
        i.imm = imm;
        i.use_imm = use_imm;
        return i;
    endfunction

    // registers 0 to 7 only, so dependences are frequent
    task automatic random_insn(input logic lane0, output issue_t i);
        int r;
        int k;
        r = $random(seed);
        k = $unsigned(r >> 18) % 11;
        if (lane0 && r[15:13] == 3'd0) k = 11 + ((r >> 16) & 3);
        i.en = (r[2:0] != 3'd0);
        i.op = exe_op_e'(k[3:0]);
        i.rd = {2'b00, r[5:3]};
        i.rj = {2'b00, r[8:6]};
        i.rk = {2'b00, r[11:9]};
        i.use_imm = r[12];
        r = $random(seed);
        case (r[1:0])
            2'd0:    i.imm = '0;
            2'd1:    i.imm = '1;
            2'd2:    i.imm = 32'h8000_0000;
            default: i.imm = $random(seed);
        endcase
    endtask

    task automatic retire(input issue_t i);
        logic [xlen-1:0] v;
        v = model_result(i.op, model_rf[i.rj], i.use_imm ? i.imm : model_rf[i.rk]);
        if (i.en && i.rd != '0) begin
            model_rf[i.rd] = v;
            chk0.expect_wb(i.rd, v);
        end
    endtask

    // holds the bundle while stalled, flush_at counts hold cycles
    task automatic run_bundle(input issue_t i0, input issue_t i1, input int flush_at);
        int   hold;
        logic stalled;
        logic finished;
        hold = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            issue0 = i0;
            issue1 = i1;
            flush = (hold == flush_at);
            rf_data00 = shadow_rf[i0.rj];
            rf_data01 = shadow_rf[i0.rk];
            rf_data10 = shadow_rf[i1.rj];
            rf_data11 = shadow_rf[i1.rk];
            #1;
            stalled = stall;
            @(posedge clk);
            if (flush) begin
                finished = 1'b1;
                @(negedge clk);
                issue0 = '0;
                issue1 = '0;
                flush = 1'b0;
                model_rf = shadow_rf;
                chk0.discard_all();
            end else if (!stalled) begin
                finished = 1'b1;
                retire(i0);
                retire(i1);
            end
            hold++;
        end
    endtask

    initial begin
        issue_t i0, i1;
        int     r, fa;
        seed = 32'hc974_182c;
        issue0 = '0;
        issue1 = '0;
        flush = 1'b0;
        rf_data00 = '0;
        rf_data01 = '0;
        rf_data10 = '0;
        rf_data11 = '0;
        for (int k = 0; k < 32; k++) model_rf[k] = '0;
        @(posedge arst_n);
        // most negative value over minus one, then zero divisors
        run_bundle(insn(op_add, 1, 0, 0, 32'h8000_0000, 1), insn(op_add, 2, 0, 0, '1, 1), -1);
        run_bundle(insn(op_div_w, 3, 1, 2, '0, 0), '0, -1);
        run_bundle(insn(op_mod_w, 4, 1, 0, '0, 1), insn(op_sub, 5, 2, 1, '0, 0), -1);
        run_bundle(insn(op_div_wu, 6, 1, 0, '0, 1), '0, -1);
        for (int n = 0; n < n_random; n++) begin
            random_insn(1'b1, i0);
            random_insn(1'b0, i1);
            if (i1.rj == i0.rd) i1.rj = '0;
            if (i1.rk == i0.rd) i1.rk = '0;
            r = $random(seed);
            fa = -1;
            if (i0.en && i0.op inside {op_div_w, op_div_wu, op_mod_w, op_mod_wu}) begin
                if (r[1:0] == 2'd0) fa = int'(r[6:2]);
            end else if (r[12:8] == 5'd0) begin
                fa = 0;
            end
            run_bundle(i0, i1, fa);
        end
        @(negedge clk);
        issue0 = '0;
        issue1 = '0;
        while (chk0.pending_count() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("checked %0d writebacks, mismatches %0d, other errors %0d",
                 checked, mismatches, other_errs);
        if (mismatches + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
